// File: ft_link_consts.svh
// Timing marks, framing symbols and sizes of the FIFO byte pipe
// Included by every module that needs a cycle mark or a symbol
`ifndef FT_LINK_CONSTS_SVH
`define FT_LINK_CONSTS_SVH

// Read cycle marks, counted from cycle start
`define FT_RD_END 25
`define FT_RD_SAMPLE 9
`define FT_RD_STROBE_START 2
`define FT_RD_STROBE_STOP 12

// Write cycle marks, OE window encloses the WR pulse
`define FT_WR_END 25
`define FT_WR_STROBE_START 5
`define FT_WR_STROBE_STOP 15
`define FT_WR_OE_START 2
`define FT_WR_OE_STOP 22

// Packet framing
`define HEADER_SYMBOL 8'h55
`define HEADER_COUNT 12
`define TRAILER_SYMBOL 8'hAA
`define TRAILER_COUNT 8
`define ERROR_SYMBOL 8'hEE
`define MIN_PACKET_LENGTH 12

// Payload store, 2048 bytes
`define RAM_WORDS 1024

`endif

// File: ft_link_pkg.sv
// Shared types of the FIFO byte pipe
// Referenced by scoped names from the modules

package ft_link_pkg;

	// One FIFO byte
	typedef logic [7:0] byte_t;
	// Length, service type or RAM word
	typedef logic [15:0] word_t;
	// Payload word index
	typedef logic [9:0] ram_addr_t;
	// Position inside a read or write cycle
	typedef logic [4:0] cycle_cnt_t;

	// Reply sequencer states
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_WAIT_RAM,
		TX_SEND
	} tx_state_t;

endpackage

// File: ft_read_port.sv
// Read side of the FT245R-style FIFO
// Each falling edge of the receive-ready line gives one timed read cycle
// and one rx_valid pulse with the sampled byte
`timescale 1ns/100ps
`include "ft_link_consts.svh"

module ft_read_port (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               ft_rxf_n,
	input  ft_link_pkg::byte_t ft_data_in,
	output logic               ft_rd_n,
	output ft_link_pkg::byte_t rx_byte,
	output logic               rx_valid,
	output logic               rd_active
);

	logic [1:0] rxf_sync;
	logic rxf_last;
	logic rxf_fall;
	logic rd_pending;
	logic rd_strobe;
	ft_link_pkg::cycle_cnt_t rd_cnt;

	// Falling edge of the synchronized ready line
	assign rxf_fall = rxf_last & ~rxf_sync[1];
	assign ft_rd_n = ~rd_strobe;

	// ========================================
	// Edge detect and cycle timing
	// ========================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rxf_sync <= 2'b11;
			rxf_last <= 1'b1;
			rd_pending <= 1'b0;
			rd_active <= 1'b0;
			rd_cnt <= '0;
			rd_strobe <= 1'b0;
			rx_valid <= 1'b0;
		end else begin
			rxf_sync <= {rxf_sync[0], ft_rxf_n};
			rxf_last <= rxf_sync[1];
			rx_valid <= 1'b0;
			// Edge during a running cycle waits for its end
			if (rxf_fall)
				rd_pending <= 1'b1;
			if (!rd_active) begin
				rd_cnt <= '0;
				if (rd_pending || rxf_fall) begin
					rd_active <= 1'b1;
					rd_pending <= 1'b0;
				end
			end else begin
				rd_cnt <= rd_cnt + 1'b1;
				if (rd_cnt == `FT_RD_STROBE_START)
					rd_strobe <= 1'b1;
				if (rd_cnt == `FT_RD_STROBE_STOP)
					rd_strobe <= 1'b0;
				// Byte handed on one clock after the sample
				if (rd_cnt == `FT_RD_SAMPLE)
					rx_valid <= 1'b1;
				if (rd_cnt == `FT_RD_END) begin
					rd_active <= 1'b0;
					rd_cnt <= '0;
				end
			end
		end
	end

	// Data bus latch at the sample mark
	always_ff @(posedge clk) begin
		if (rd_active && rd_cnt == `FT_RD_SAMPLE)
			rx_byte <= ft_data_in;
	end

	// Strobe must stay inside its cycle
	assert property (@(posedge clk) disable iff (!rst_n) !ft_rd_n |-> rd_active)
		else $error("read strobe low outside a read cycle");

endmodule

// File: packet_receiver.sv
// Packet receiver of the FIFO byte pipe
// Hunts for the header run, captures length and service type, packs the
// payload into RAM words and closes the packet on the trailer or an error
// Held fields stay stable until the next header, which waits for the reply
`timescale 1ns/100ps
`include "ft_link_consts.svh"

module packet_receiver (
	input  logic                   clk,
	input  logic                   rst_n,
	input  ft_link_pkg::byte_t     rx_byte,
	input  logic                   rx_valid,
	input  logic                   reply_active,
	output logic                   ram_we,
	output ft_link_pkg::ram_addr_t ram_waddr,
	output ft_link_pkg::word_t     ram_wdata,
	output ft_link_pkg::word_t     packet_length,
	output ft_link_pkg::word_t     service_type,
	output logic                   packet_error,
	output logic                   packet_active,
	output logic                   packet_done,
	output logic                   header_recognized,
	output logic                   trailer_recognized
);

	logic [3:0] hdr_cnt;
	logic [3:0] trl_cnt;
	ft_link_pkg::word_t byte_cnt;
	ft_link_pkg::word_t count_next;
	ft_link_pkg::word_t pay_word;
	ft_link_pkg::byte_t lo_byte;
	logic finish;
	logic hunt;
	logic in_body;
	logic pay_byte;
	logic trailer_done;
	logic too_short;
	logic overrun;

	// Header search idles while a packet or its reply is in flight
	assign hunt = !packet_active && !finish && !packet_done && !reply_active;
	// byte_cnt is the index after the header
	assign count_next = byte_cnt + 16'd1;
	assign in_body = byte_cnt >= 16'd4;
	assign pay_byte = in_body && (count_next <= packet_length - `TRAILER_COUNT);
	assign pay_word = (byte_cnt - 16'd4) >> 1;
	assign trailer_done = in_body && (rx_byte == `TRAILER_SYMBOL)
		&& (trl_cnt == `TRAILER_COUNT - 1);
	// Length checked as the service type starts
	assign too_short = (byte_cnt == 16'd2) && (packet_length < `MIN_PACKET_LENGTH);
	assign overrun = in_body && !trailer_done && (count_next > packet_length);

	// ========================================
	// Framing control
	// ========================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hdr_cnt <= '0;
			trl_cnt <= '0;
			byte_cnt <= '0;
			packet_active <= 1'b0;
			packet_error <= 1'b0;
			header_recognized <= 1'b0;
			trailer_recognized <= 1'b0;
			finish <= 1'b0;
			packet_done <= 1'b0;
			ram_we <= 1'b0;
		end else begin
			header_recognized <= 1'b0;
			trailer_recognized <= 1'b0;
			ram_we <= 1'b0;
			finish <= 1'b0;
			packet_done <= finish;
			if (!hunt)
				hdr_cnt <= '0;
			// Header run, any other byte restarts it
			if (rx_valid && hunt) begin
				if (rx_byte != `HEADER_SYMBOL) begin
					hdr_cnt <= '0;
				end else if (hdr_cnt == `HEADER_COUNT - 1) begin
					hdr_cnt <= '0;
					header_recognized <= 1'b1;
					packet_active <= 1'b1;
					packet_error <= 1'b0;
					byte_cnt <= '0;
					trl_cnt <= '0;
				end else begin
					hdr_cnt <= hdr_cnt + 4'd1;
				end
			end
			if (rx_valid && packet_active) begin
				byte_cnt <= count_next;
				// Trailer run only counted past the fields
				if (in_body)
					trl_cnt <= (rx_byte == `TRAILER_SYMBOL) ? trl_cnt + 4'd1 : '0;
				// Odd payload byte completes a word
				if (pay_byte && byte_cnt[0])
					ram_we <= 1'b1;
				if (too_short || overrun || trailer_done) begin
					packet_active <= 1'b0;
					finish <= 1'b1;
					trailer_recognized <= trailer_done;
					packet_error <= too_short || overrun || (count_next != packet_length);
				end
			end
		end
	end

	// Field and payload capture, low byte first
	always_ff @(posedge clk) begin
		if (rx_valid && packet_active) begin
			case (byte_cnt)
				16'd0: packet_length[7:0] <= rx_byte;
				16'd1: packet_length[15:8] <= rx_byte;
				16'd2: service_type[7:0] <= rx_byte;
				16'd3: service_type[15:8] <= rx_byte;
				default: ;
			endcase
			if (pay_byte && !byte_cnt[0])
				lo_byte <= rx_byte;
			if (pay_byte && byte_cnt[0]) begin
				ram_wdata <= {rx_byte, lo_byte};
				ram_waddr <= pay_word[9:0];
			end
		end
	end

	// Payload must fit the RAM, no address wrap
	assert property (@(posedge clk) disable iff (!rst_n)
		(rx_valid && packet_active && pay_byte) |-> (pay_word < `RAM_WORDS))
		else $error("payload word index beyond the RAM");

endmodule

// File: payload_ram.sv
// Payload word store between receiver and reply
// Write and read ports share one clock, reads come one clock later
`timescale 1ns/100ps
`include "ft_link_consts.svh"

module payload_ram (
	input  logic                   clk,
	input  logic                   we,
	input  ft_link_pkg::ram_addr_t waddr,
	input  ft_link_pkg::ram_addr_t raddr,
	input  ft_link_pkg::word_t     wdata,
	output ft_link_pkg::word_t     rdata
);

	ft_link_pkg::word_t mem [0:`RAM_WORDS-1];

	// Write port, receiver side
	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Registered read, reply side
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

// File: reply_sequencer.sv
// Reply byte sequencer
// Walks header, length, service field, payload loopback and trailer
// one byte per write cycle, fetching a RAM word ahead of each word pair
`timescale 1ns/100ps
`include "ft_link_consts.svh"

module reply_sequencer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   packet_done,
	input  logic                   packet_error,
	input  ft_link_pkg::word_t     packet_length,
	input  ft_link_pkg::word_t     service_type,
	input  ft_link_pkg::word_t     ram_rdata,
	input  logic                   tx_done,
	output ft_link_pkg::ram_addr_t ram_raddr,
	output ft_link_pkg::byte_t     tx_byte,
	output logic                   tx_start,
	output logic                   reply_active
);

	ft_link_pkg::tx_state_t state;
	ft_link_pkg::word_t idx;
	ft_link_pkg::word_t next_idx;
	ft_link_pkg::word_t reply_len;
	ft_link_pkg::word_t pay_end;
	ft_link_pkg::word_t next_off;
	logic in_flight;
	logic fetch;

	// Error reply has no payload
	assign reply_len = packet_error ? 16'(`HEADER_COUNT + 4 + `TRAILER_COUNT)
		: packet_length + 16'(`HEADER_COUNT);
	assign pay_end = reply_len - 16'(`TRAILER_COUNT);
	assign next_idx = idx + 16'd1;
	assign next_off = next_idx - 16'(`HEADER_COUNT + 4);
	// Even payload byte needs a fresh word
	assign fetch = (next_idx >= `HEADER_COUNT + 4) && (next_idx < pay_end) && !next_idx[0];
	assign tx_start = (state == ft_link_pkg::TX_SEND) && !in_flight;

	// ========================================
	// Byte select
	// ========================================
	always_comb begin
		if (idx < `HEADER_COUNT)
			tx_byte = `HEADER_SYMBOL;
		else if (idx == `HEADER_COUNT)
			tx_byte = packet_length[7:0];
		else if (idx == `HEADER_COUNT + 1)
			tx_byte = packet_length[15:8];
		else if (idx == `HEADER_COUNT + 2)
			tx_byte = packet_error ? `ERROR_SYMBOL : service_type[7:0];
		else if (idx == `HEADER_COUNT + 3)
			tx_byte = packet_error ? `ERROR_SYMBOL : service_type[15:8];
		else if (idx < pay_end)
			tx_byte = idx[0] ? ram_rdata[15:8] : ram_rdata[7:0];
		else
			tx_byte = `TRAILER_SYMBOL;
	end

	// Pacing FSM, one byte in flight at a time
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ft_link_pkg::TX_IDLE;
			idx <= '0;
			in_flight <= 1'b0;
			reply_active <= 1'b0;
		end else begin
			case (state)
				ft_link_pkg::TX_IDLE: begin
					if (packet_done) begin
						idx <= '0;
						in_flight <= 1'b0;
						reply_active <= 1'b1;
						state <= ft_link_pkg::TX_SEND;
					end
				end
				// RAM read latency
				ft_link_pkg::TX_WAIT_RAM: state <= ft_link_pkg::TX_SEND;
				ft_link_pkg::TX_SEND: begin
					if (tx_start) begin
						in_flight <= 1'b1;
					end else if (tx_done) begin
						in_flight <= 1'b0;
						if (next_idx == reply_len) begin
							state <= ft_link_pkg::TX_IDLE;
							reply_active <= 1'b0;
						end else begin
							idx <= next_idx;
							if (fetch)
								state <= ft_link_pkg::TX_WAIT_RAM;
						end
					end
				end
				default: state <= ft_link_pkg::TX_IDLE;
			endcase
		end
	end

	// Word address for the next byte pair
	always_ff @(posedge clk) begin
		if (state == ft_link_pkg::TX_SEND && tx_done && fetch)
			ram_raddr <= next_off[10:1];
	end

endmodule

// File: ft_write_port.sv
// Write side of the FT245R-style FIFO
// Holds one requested byte until transmit-ready is low, then runs a
// timed OE and WR window and reports tx_done at the end
`timescale 1ns/100ps
`include "ft_link_consts.svh"

module ft_write_port (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               ft_txe_n,
	input  ft_link_pkg::byte_t tx_byte,
	input  logic               tx_start,
	output ft_link_pkg::byte_t ft_data_out,
	output logic               ft_wr,
	output logic               ft_oe,
	output logic               tx_done,
	output logic               wr_active
);

	logic [1:0] txe_sync;
	logic pending;
	ft_link_pkg::cycle_cnt_t wr_cnt;

	// ========================================
	// Back-pressure and cycle timing
	// ========================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			txe_sync <= 2'b11;
			pending <= 1'b0;
			wr_active <= 1'b0;
			wr_cnt <= '0;
			ft_wr <= 1'b0;
			ft_oe <= 1'b0;
			tx_done <= 1'b0;
		end else begin
			txe_sync <= {txe_sync[0], ft_txe_n};
			tx_done <= 1'b0;
			if (tx_start)
				pending <= 1'b1;
			if (!wr_active) begin
				wr_cnt <= '0;
				// Chip full holds the byte here
				if (pending && !txe_sync[1]) begin
					wr_active <= 1'b1;
					pending <= 1'b0;
				end
			end else begin
				wr_cnt <= wr_cnt + 1'b1;
				if (wr_cnt == `FT_WR_OE_START)
					ft_oe <= 1'b1;
				if (wr_cnt == `FT_WR_OE_STOP)
					ft_oe <= 1'b0;
				if (wr_cnt == `FT_WR_STROBE_START)
					ft_wr <= 1'b1;
				if (wr_cnt == `FT_WR_STROBE_STOP)
					ft_wr <= 1'b0;
				if (wr_cnt == `FT_WR_END) begin
					wr_active <= 1'b0;
					wr_cnt <= '0;
					tx_done <= 1'b1;
				end
			end
		end
	end

	// Byte bus loaded with the request
	always_ff @(posedge clk) begin
		if (tx_start)
			ft_data_out <= tx_byte;
	end

	// Strobe nested in the output-enable window
	assert property (@(posedge clk) disable iff (!rst_n) ft_wr |-> ft_oe)
		else $error("write strobe outside the output enable window");

	// Sequencer waits for the previous byte to finish
	assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !wr_active && !pending)
		else $error("byte request during an active write cycle");

endmodule

// File: ft_usb_link.sv
// Top level of the FIFO byte-pipe packet engine
// Read port, receiver, payload RAM, reply sequencer and write port
`timescale 1ns/100ps

module ft_usb_link (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               ft_rxf_n,
	input  logic               ft_txe_n,
	input  ft_link_pkg::byte_t ft_data_in,
	output logic               ft_rd_n,
	output logic               ft_wr,
	output ft_link_pkg::byte_t ft_data_out,
	output logic               ft_oe,
	output logic               usb_active,
	output logic               header_recognized,
	output logic               trailer_recognized,
	output logic               packet_active,
	output logic               ram_we
);

	// Receive path
	ft_link_pkg::byte_t rx_byte;
	logic rx_valid;
	logic rd_active;
	// Payload RAM ports
	ft_link_pkg::ram_addr_t ram_waddr;
	ft_link_pkg::ram_addr_t ram_raddr;
	ft_link_pkg::word_t ram_wdata;
	ft_link_pkg::word_t ram_rdata;
	// Held packet fields
	ft_link_pkg::word_t packet_length;
	ft_link_pkg::word_t service_type;
	logic packet_error;
	logic packet_done;
	// Transmit path
	logic reply_active;
	ft_link_pkg::byte_t tx_byte;
	logic tx_start;
	logic tx_done;
	logic wr_active;

	// Bus busy in either direction
	assign usb_active = rd_active | wr_active;

	ft_read_port i_ft_read_port (.*);

	packet_receiver i_packet_receiver (.*);

	payload_ram i_payload_ram (
		.clk   (clk),
		.we    (ram_we),
		.waddr (ram_waddr),
		.raddr (ram_raddr),
		.wdata (ram_wdata),
		.rdata (ram_rdata)
	);

	reply_sequencer i_reply_sequencer (.*);

	ft_write_port i_ft_write_port (.*);

endmodule

// File: tb_ft_usb_link.sv
// Testbench of the FIFO byte-pipe packet engine
// Models the FT245R-style chip on both sides, replays the packets of
// ft_link_tests.txt and checks each reply against the framing rules
// Run from the project root so the test file is found
`timescale 1ns/100ps
`include "ft_link_consts.svh"

module tb_ft_usb_link;

	logic clk;
	logic rst_n;
	logic ft_rxf_n;
	logic ft_txe_n;
	ft_link_pkg::byte_t ft_data_in;
	logic ft_rd_n;
	logic ft_wr;
	ft_link_pkg::byte_t ft_data_out;
	logic ft_oe;
	logic usb_active;
	logic header_recognized;
	logic trailer_recognized;
	logic packet_active;
	logic ram_we;

	// Test table with the packet bytes in one flat queue
	string test_name[$];
	int reply_bytes[$];
	ft_link_pkg::word_t service_exp[$];
	int we_exp[$];
	int pkt_start[$];
	int pkt_len[$];
	ft_link_pkg::byte_t pkt[$];

	// Reply capture and run control
	ft_link_pkg::byte_t captured[$];
	int we_count = 0;
	int hdr_count = 0;
	int trl_count = 0;
	int active_rises = 0;
	logic active_last = 1'b0;
	int cycle_count = 0;
	int cycle_limit = 0;
	int hold_cycles = 0;
	logic [31:0] lcg_state = 32'h25dcfe4b;

	ft_usb_link i_ft_usb_link (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ========================================
	// Reporting and compare tasks
	// ========================================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_byte(input string what, input ft_link_pkg::byte_t expected,
		input ft_link_pkg::byte_t actual);
		if (expected !== actual) begin
			$display("** Error: %s: expected %h, actual %h", what, expected, actual);
			abort_run("reply byte mismatch");
		end
	endtask

	task automatic check_word(input string what, input ft_link_pkg::word_t expected,
		input ft_link_pkg::word_t actual);
		if (expected !== actual) begin
			$display("** Error: %s: expected %h, actual %h", what, expected, actual);
			abort_run("word value mismatch");
		end
	endtask

	// Numerical Recipes constants with full 32-bit wrap
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Reply byte i of test t outside the service field
	function automatic ft_link_pkg::byte_t expected_reply_byte(input int t, input int i);
		if (i < `HEADER_COUNT)
			return `HEADER_SYMBOL;
		if (i >= reply_bytes[t] - `TRAILER_COUNT)
			return `TRAILER_SYMBOL;
		// Length bytes and loopback payload keep their packet offsets
		return pkt[pkt_start[t] + i];
	endfunction

	// Trailer pulses of test t, none when reception ends early
	function automatic int trailer_expected(input int t);
		int base;
		int len;
		int run;
		int n;
		base = pkt_start[t] + `HEADER_COUNT;
		len = {pkt[base + 1], pkt[base]};
		// Short length ends the packet as the service type starts
		if (len < `MIN_PACKET_LENGTH)
			return 0;
		run = 0;
		for (n = 4; n < pkt_len[t] - `HEADER_COUNT; n++) begin
			run = (pkt[base + n] == `TRAILER_SYMBOL) ? run + 1 : 0;
			if (run == `TRAILER_COUNT)
				return 1;
			// Byte count past the length field
			if (n + 1 > len)
				return 0;
		end
		return 0;
	endfunction

	// Inactive levels while reset holds
	task automatic verify_idle_outputs();
		check_word("reset ft_rd_n", 16'd1, 16'(ft_rd_n));
		check_word("reset ft_wr", 16'd0, 16'(ft_wr));
		check_word("reset ft_oe", 16'd0, 16'(ft_oe));
		check_word("reset ram_we", 16'd0, 16'(ram_we));
		check_word("reset packet_active", 16'd0, 16'(packet_active));
		check_word("reset usb_active", 16'd0, 16'(usb_active));
	endtask

	// ========================================
	// Test file reader
	// ========================================
	task automatic load_tests();
		int fd;
		int code;
		int rlen;
		int wes;
		int nb;
		int k;
		string token;
		string line;
		ft_link_pkg::word_t svc;
		ft_link_pkg::byte_t value;
		fd = $fopen("ft_link_tests.txt", "r");
		if (fd == 0)
			abort_run("cannot open the test file ft_link_tests.txt");
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", token);
			if (code != 1)
				break;
			// Comment line is dropped up to its end
			if (token.substr(0, 0) == "#") begin
				code = $fgets(line, fd);
				continue;
			end
			code = $fscanf(fd, "%d %h %d %d", rlen, svc, wes, nb);
			if (code != 4)
				abort_run("malformed test line in the test file");
			test_name.push_back(token);
			reply_bytes.push_back(rlen);
			service_exp.push_back(svc);
			we_exp.push_back(wes);
			pkt_start.push_back(pkt.size());
			pkt_len.push_back(nb);
			for (k = 0; k < nb; k++) begin
				code = $fscanf(fd, "%h", value);
				if (code != 1)
					abort_run("test file ends inside a packet");
				pkt.push_back(value);
			end
		end
		$fclose(fd);
		if (test_name.size() == 0)
			abort_run("no tests found in the test file");
	endtask

	// ========================================
	// FIFO chip model
	// ========================================
	// One byte per receive-ready low phase
	task automatic send_byte(input ft_link_pkg::byte_t value);
		ft_rxf_n = 1'b0;
		while (ft_rd_n)
			@(negedge clk);
		ft_data_in = value;
		while (!ft_rd_n)
			@(negedge clk);
		ft_rxf_n = 1'b1;
		// High long enough for a fresh falling edge
		repeat (2) @(negedge clk);
	endtask

	// Random transmit-ready hold-offs
	always @(negedge clk) begin
		if (hold_cycles > 0) begin
			hold_cycles = hold_cycles - 1;
			ft_txe_n = 1'b1;
		end else begin
			lcg_state = lcg_next(lcg_state);
			if (lcg_state[31:28] == 4'd0) begin
				hold_cycles = lcg_state[26:24];
				ft_txe_n = 1'b1;
			end else begin
				ft_txe_n = 1'b0;
			end
		end
	end

	// Byte written by the DUT on each WR falling edge
	always @(negedge ft_wr) begin
		if (rst_n)
			captured.push_back(ft_data_out);
	end

	// RAM writes, framing pulses and strobe nesting
	always @(negedge clk) begin
		if (rst_n) begin
			if (ram_we)
				we_count = we_count + 1;
			if (header_recognized)
				hdr_count = hdr_count + 1;
			if (trailer_recognized)
				trl_count = trl_count + 1;
			if (packet_active && !active_last)
				active_rises = active_rises + 1;
			active_last = packet_active;
			if (ft_wr && !ft_oe)
				abort_run("write strobe high while output enable is low");
			// Busy flag covers both bus directions
			if ((ft_oe || !ft_rd_n) && !usb_active)
				abort_run("usb_active low during a FIFO bus cycle");
		end
	end

	// Run length guard
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit != 0 && cycle_count > cycle_limit)
			abort_run("timeout: the run took longer than the cycle limit");
	end

	// ========================================
	// Regression control
	// ========================================
	task automatic run_test(input int t);
		int k;
		string name;
		name = test_name[t];
		captured.delete();
		we_count = 0;
		hdr_count = 0;
		trl_count = 0;
		active_rises = 0;
		for (k = 0; k < pkt_len[t]; k++)
			send_byte(pkt[pkt_start[t] + k]);
		while (captured.size() < reply_bytes[t])
			@(negedge clk);
		while (usb_active)
			@(negedge clk);
		// Any extra reply byte would show in this quiet window
		repeat (40) @(negedge clk);
		check_word({name, " reply length"}, 16'(reply_bytes[t]), 16'(captured.size()));
		check_word({name, " service field"}, service_exp[t],
			{captured[`HEADER_COUNT + 3], captured[`HEADER_COUNT + 2]});
		for (k = 0; k < reply_bytes[t]; k++) begin
			if (k != `HEADER_COUNT + 2 && k != `HEADER_COUNT + 3)
				check_byte($sformatf("%s reply byte %0d", name, k),
					expected_reply_byte(t, k), captured[k]);
		end
		check_word({name, " ram writes"}, 16'(we_exp[t]), 16'(we_count));
		check_word({name, " header pulses"}, 16'd1, 16'(hdr_count));
		check_word({name, " trailer pulses"}, 16'(trailer_expected(t)), 16'(trl_count));
		check_word({name, " packet_active rises"}, 16'd1, 16'(active_rises));
		check_word({name, " packet_active at end"}, 16'd0, 16'(packet_active));
	endtask

	initial begin
		int t;
		int limit;
		rst_n = 1'b0;
		ft_rxf_n = 1'b1;
		ft_txe_n = 1'b1;
		ft_data_in = '0;
		load_tests();
		limit = 1000;
		for (t = 0; t < test_name.size(); t++)
			limit = limit + 30 * (pkt_len[t] + reply_bytes[t]);
		cycle_limit = limit;
		repeat (4) @(negedge clk);
		verify_idle_outputs();
		rst_n = 1'b1;
		for (t = 0; t < test_name.size(); t++)
			run_test(t);
		$display("Regression passed");
		$finish;
	end

endmodule

// File: ft_link_tests.txt
# name reply_bytes service(hex) ram_we_pulses packet_bytes, then the packet bytes in hex
# Packet bytes include header and trailer and may continue over several lines
min_packet 24 1234 0 24
 55 55 55 55 55 55 55 55 55 55 55 55
 0C 00 34 12
 AA AA AA AA AA AA AA AA
payload6 30 0007 3 30
 55 55 55 55 55 55 55 55 55 55 55 55
 12 00 07 00 01 02 03 04 05 06
 AA AA AA AA AA AA AA AA
short_length 24 EEEE 0 24
 55 55 55 55 55 55 55 55 55 55 55 55
 08 00 11 22
 AA AA AA AA AA AA AA AA
length_mismatch 24 EEEE 4 28
 55 55 55 55 55 55 55 55 55 55 55 55
 14 00 21 43 01 02 03 04
 AA AA AA AA AA AA AA AA
overrun 24 EEEE 1 28
 55 55 55 55 55 55 55 55 55 55 55 55
 0E 00 65 87 01 02 03 04
 AA AA AA AA AA AA AA AA
long_payload 44 5A3C 10 44
 55 55 55 55 55 55 55 55 55 55 55 55
 20 00 3C 5A 10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D 1E 1F 20 21 22 23
 AA AA AA AA AA AA AA AA

// File: files.f
+incdir+.
ft_link_pkg.sv
ft_read_port.sv
packet_receiver.sv
payload_ram.sv
reply_sequencer.sv
ft_write_port.sv
ft_usb_link.sv
tb_ft_usb_link.sv

// File: Bender.yml
package:
  name: ft_usb_link

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ft_link_pkg.sv
      - ft_read_port.sv
      - packet_receiver.sv
      - payload_ram.sv
      - reply_sequencer.sv
      - ft_write_port.sv
      - ft_usb_link.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ft_usb_link.sv
